// File: hw/mem_access_pkg.sv
// core side view of a memory access
package mem_access_pkg;

  // byte addressed, word wide core accesses
  localparam int ADDR_W = 32;
  localparam int WORD_W = 32;
  localparam int BYTES_PER_WORD = WORD_W / 8;

  // byte address from the core
  typedef logic [ADDR_W-1:0] addr_t;

  // one data word, read or write
  typedef logic [WORD_W-1:0] word_t;

  // active low byte write mask, one bit per byte lane
  typedef logic [BYTES_PER_WORD-1:0] byte_mask_n_t;

  // all lanes masked off, the core's way of saying no write
  localparam byte_mask_n_t NO_WRITE_MASK = '1;

  // kind of a queued request
  typedef enum logic {
    req_read  = 1'b0,
    req_write = 1'b1
  } req_kind_e;

endpackage

// File: hw/axi_lite_pkg.sv
// AXI4-Lite bus types
package axi_lite_pkg;

  localparam int AXI_ADDR_W = 32;
  localparam int AXI_DATA_W = 32;
  localparam int AXI_STRB_W = AXI_DATA_W / 8;

  typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [AXI_DATA_W-1:0] axi_data_t;

  // active high byte strobe
  typedef logic [AXI_STRB_W-1:0] axi_strb_t;

  // bresp / rresp encoding
  typedef enum logic [1:0] {
    axi_okay   = 2'b00,
    axi_exokay = 2'b01,
    axi_slverr = 2'b10,
    axi_decerr = 2'b11
  } axi_resp_e;

  // slave or decode error, anything but okay and exokay
  function automatic logic resp_is_err(axi_resp_e resp);
    return (resp == axi_slverr) || (resp == axi_decerr);
  endfunction

endpackage

// File: hw/mem_req_if.sv
`timescale 1ns/1ns

// one queued memory request between two stages
// transfer on a clock edge with valid and ready both high
interface mem_req_if;
  import mem_access_pkg::*;
  import axi_lite_pkg::*;

  logic      valid;
  logic      ready;
  req_kind_e kind;
  addr_t     addr;
  word_t     wdata;
  // already active high here
  axi_strb_t wstrb;

  // side that offers requests
  modport producer(
    output valid, kind, addr, wdata, wstrb,
    input ready
  );

  // side that takes requests
  modport consumer(
    input valid, kind, addr, wdata, wstrb,
    output ready
  );

endinterface

// File: hw/core_req_port.sv
`timescale 1ns/1ns

// core facing request stage
// level request plus stall toward the core, queued requests toward the bus
module core_req_port #(
  parameter int FIFO_DEPTH = 2
) (
  input  logic                         clk,
  input  logic                         reset_i,
  // core side
  input  logic                         req_i,
  input  logic                         write_i,
  input  mem_access_pkg::byte_mask_n_t mask_n_i,
  input  mem_access_pkg::addr_t        addr_i,
  input  mem_access_pkg::word_t        wdata_i,
  output mem_access_pkg::word_t        rdata_o,
  output logic                         stall_o,
  // response from the bus engine
  input  logic                         rsp_valid_i,
  input  logic                         rsp_err_i,
  input  mem_access_pkg::word_t        rsp_data_i,
  // sticky bus error
  output logic                         err_o,
  // queue entrance
  mem_req_if.producer                  req
);
  import mem_access_pkg::*;

  typedef enum logic [1:0] {
    idle,
    wait_read,
    done
  } port_state_e;

  port_state_e state_q;
  port_state_e state_d;
  word_t       rdata_q;
  logic        err_q;
  logic        is_write;

  // queue depth has to be a power of two, two or more
  if (FIFO_DEPTH < 2 || (FIFO_DEPTH & (FIFO_DEPTH - 1)) != 0) begin : g_depth_check
    $error("core_req_port: FIFO_DEPTH must be a power of two of at least 2");
  end

  // mask of all ones is a no write, drop it here
  assign is_write = write_i && (mask_n_i != NO_WRITE_MASK);

  // request fields follow the core directly
  assign req.kind  = write_i ? req_write : req_read;
  assign req.addr  = addr_i;
  assign req.wdata = wdata_i;
  // active low core mask to active high bus strobe
  assign req.wstrb = write_i ? ~mask_n_i : '0;

  always_comb begin
    state_d   = state_q;
    req.valid = 1'b0;
    stall_o   = 1'b0;
    case (state_q)
      idle: begin
        if (req_i && write_i) begin
          // posted write, hold core only on a full queue
          req.valid = is_write;
          stall_o   = is_write && !req.ready;
        end else if (req_i) begin
          // read stalls from the very first cycle
          req.valid = 1'b1;
          stall_o   = 1'b1;
          if (req.ready) begin
            state_d = wait_read;
          end
        end
      end
      wait_read: begin
        stall_o = 1'b1;
        if (rsp_valid_i) begin
          state_d = done;
        end
      end
      done: begin
        // data valid, stall low, request ignored this cycle
        state_d = idle;
      end
      default: begin
        state_d = idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= idle;
    end else begin
      state_q <= state_d;
    end
  end

  // read data register, loaded by the response pulse
  always_ff @(posedge clk) begin
    if (rsp_valid_i) begin
      rdata_q <= rsp_data_i;
    end
  end

  // sticky error, only reset clears it
  always_ff @(posedge clk) begin
    if (reset_i) begin
      err_q <= 1'b0;
    end else if (rsp_err_i) begin
      err_q <= 1'b1;
    end
  end

  assign rdata_o = rdata_q;
  assign err_o   = err_q;

  // the bus engine only answers a read this port is waiting on
  a_rsp_only_in_wait : assert property (
    @(posedge clk) disable iff (reset_i)
    rsp_valid_i |-> (state_q == wait_read)
  );

endmodule

// File: hw/req_fifo.sv
`timescale 1ns/1ns

// circular request queue
// push and pop may happen in the same cycle
module req_fifo #(
  parameter int FIFO_DEPTH = 2
) (
  input logic         clk,
  input logic         reset_i,
  mem_req_if.consumer in,
  mem_req_if.producer out
);
  import mem_access_pkg::*;
  import axi_lite_pkg::*;

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  // storage, one array per field
  req_kind_e kind_mem  [FIFO_DEPTH];
  addr_t     addr_mem  [FIFO_DEPTH];
  word_t     wdata_mem [FIFO_DEPTH];
  axi_strb_t wstrb_mem [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  assign push = in.valid && in.ready;
  assign pop  = out.valid && out.ready;

  // not full
  assign in.ready  = (count_q != CNT_W'(FIFO_DEPTH));
  // head entry shows up the cycle after its push
  assign out.valid = (count_q != '0);
  assign out.kind  = kind_mem[rd_ptr_q];
  assign out.addr  = addr_mem[rd_ptr_q];
  assign out.wdata = wdata_mem[rd_ptr_q];
  assign out.wstrb = wstrb_mem[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (push) begin
      kind_mem[wr_ptr_q]  <= in.kind;
      addr_mem[wr_ptr_q]  <= in.addr;
      wdata_mem[wr_ptr_q] <= in.wdata;
      wstrb_mem[wr_ptr_q] <= in.wstrb;
    end
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  a_count_bound : assert property (
    @(posedge clk) disable iff (reset_i)
    count_q <= CNT_W'(FIFO_DEPTH)
  );

endmodule

// File: hw/axi_lite_master.sv
`timescale 1ns/1ns

// AXI4-Lite bus engine
// pops one request at a time and runs it on the bus
module axi_lite_master (
  input  logic                   clk,
  input  logic                   reset_i,
  // request queue exit
  mem_req_if.consumer            req,
  // response back to the port
  output logic                   rsp_valid_o,
  output logic                   rsp_err_o,
  output mem_access_pkg::word_t  rsp_data_o,
  // write address channel
  output axi_lite_pkg::axi_addr_t awaddr_o,
  output logic                   awvalid_o,
  input  logic                   awready_i,
  // write data channel
  output axi_lite_pkg::axi_data_t wdata_o,
  output axi_lite_pkg::axi_strb_t wstrb_o,
  output logic                   wvalid_o,
  input  logic                   wready_i,
  // write response channel
  input  axi_lite_pkg::axi_resp_e bresp_i,
  input  logic                   bvalid_i,
  output logic                   bready_o,
  // read address and read data channels
  output axi_lite_pkg::axi_addr_t araddr_o,
  output logic                   arvalid_o,
  input  logic                   arready_i,
  input  axi_lite_pkg::axi_data_t rdata_i,
  input  axi_lite_pkg::axi_resp_e rresp_i,
  input  logic                   rvalid_i,
  output logic                   rready_o
);
  import mem_access_pkg::*;
  import axi_lite_pkg::*;

  typedef enum logic [2:0] {
    idle,
    addr_read,
    data_read,
    addr_write,
    resp_write
  } bus_state_e;

  bus_state_e state_q;
  bus_state_e state_d;
  // payload of the request on the bus
  addr_t      addr_q;
  word_t      wdata_q;
  axi_strb_t  wstrb_q;
  // aw and w handshakes finish on their own
  logic       aw_done_q;
  logic       w_done_q;

  // one transaction at a time, pop only when idle
  assign req.ready = (state_q == idle);

  always_comb begin
    state_d = state_q;
    case (state_q)
      idle: begin
        if (req.valid) begin
          state_d = (req.kind == req_write) ? addr_write : addr_read;
        end
      end
      addr_read: begin
        if (arready_i) begin
          state_d = data_read;
        end
      end
      data_read: begin
        if (rvalid_i) begin
          state_d = idle;
        end
      end
      addr_write: begin
        // both aw and w accepted, now or earlier
        if ((aw_done_q || awready_i) && (w_done_q || wready_i)) begin
          state_d = resp_write;
        end
      end
      resp_write: begin
        if (bvalid_i) begin
          state_d = idle;
        end
      end
      default: begin
        state_d = idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= idle;
    end else begin
      state_q <= state_d;
    end
  end

  // latch payload on pop
  always_ff @(posedge clk) begin
    if (req.valid && req.ready) begin
      addr_q  <= req.addr;
      wdata_q <= req.wdata;
      wstrb_q <= req.wstrb;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i || state_q == idle) begin
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else begin
      if (awvalid_o && awready_i) begin
        aw_done_q <= 1'b1;
      end
      if (wvalid_o && wready_i) begin
        w_done_q <= 1'b1;
      end
    end
  end

  // valids rise the cycle after the pop
  assign arvalid_o = (state_q == addr_read);
  assign araddr_o  = addr_q;
  assign awvalid_o = (state_q == addr_write) && !aw_done_q;
  assign awaddr_o  = addr_q;
  assign wvalid_o  = (state_q == addr_write) && !w_done_q;
  assign wdata_o   = wdata_q;
  assign wstrb_o   = wstrb_q;
  // ready only while waiting on that response
  assign rready_o  = (state_q == data_read);
  assign bready_o  = (state_q == resp_write);

  // read completes on the r handshake
  assign rsp_valid_o = rready_o && rvalid_i;
  assign rsp_data_o  = rdata_i;
  // error pulse for either kind
  assign rsp_err_o   = (rready_o && rvalid_i && resp_is_err(rresp_i)) ||
                       (bready_o && bvalid_i && resp_is_err(bresp_i));

  a_ar_stable : assert property (
    @(posedge clk) disable iff (reset_i)
    (arvalid_o && !arready_i) |=> (arvalid_o && $stable(araddr_o))
  );

endmodule

// File: hw/cpu_wrapper.sv
`timescale 1ns/1ns

// memory side of the core wrapper
// m0 carries instruction fetches, m1 carries data accesses
module cpu_wrapper #(
  parameter int INST_FIFO_DEPTH = 2,
  parameter int DATA_FIFO_DEPTH = 4
) (
  input  logic                          clk,
  input  logic                          reset_i,
  // instruction port
  input  logic                          inst_read_i,
  input  mem_access_pkg::addr_t         inst_addr_i,
  output mem_access_pkg::word_t         inst_data_o,
  output logic                          inst_stall_o,
  // data port
  input  logic                          data_read_i,
  input  logic                          data_write_i,
  input  mem_access_pkg::byte_mask_n_t  data_mask_n_i,
  input  mem_access_pkg::addr_t         data_addr_i,
  input  mem_access_pkg::word_t         data_wdata_i,
  output mem_access_pkg::word_t         data_rdata_o,
  output logic                          data_stall_o,
  // sticky error from either bus
  output logic                          bus_err_o,
  // m0, instruction bus
  output axi_lite_pkg::axi_addr_t       m0_awaddr_o,
  output logic                          m0_awvalid_o,
  input  logic                          m0_awready_i,
  output axi_lite_pkg::axi_data_t       m0_wdata_o,
  output axi_lite_pkg::axi_strb_t       m0_wstrb_o,
  output logic                          m0_wvalid_o,
  input  logic                          m0_wready_i,
  input  axi_lite_pkg::axi_resp_e       m0_bresp_i,
  input  logic                          m0_bvalid_i,
  output logic                          m0_bready_o,
  output axi_lite_pkg::axi_addr_t       m0_araddr_o,
  output logic                          m0_arvalid_o,
  input  logic                          m0_arready_i,
  input  axi_lite_pkg::axi_data_t       m0_rdata_i,
  input  axi_lite_pkg::axi_resp_e       m0_rresp_i,
  input  logic                          m0_rvalid_i,
  output logic                          m0_rready_o,
  // m1, data bus
  output axi_lite_pkg::axi_addr_t       m1_awaddr_o,
  output logic                          m1_awvalid_o,
  input  logic                          m1_awready_i,
  output axi_lite_pkg::axi_data_t       m1_wdata_o,
  output axi_lite_pkg::axi_strb_t       m1_wstrb_o,
  output logic                          m1_wvalid_o,
  input  logic                          m1_wready_i,
  input  axi_lite_pkg::axi_resp_e       m1_bresp_i,
  input  logic                          m1_bvalid_i,
  output logic                          m1_bready_o,
  output axi_lite_pkg::axi_addr_t       m1_araddr_o,
  output logic                          m1_arvalid_o,
  input  logic                          m1_arready_i,
  input  axi_lite_pkg::axi_data_t       m1_rdata_i,
  input  axi_lite_pkg::axi_resp_e       m1_rresp_i,
  input  logic                          m1_rvalid_i,
  output logic                          m1_rready_o
);
  import mem_access_pkg::*;

  // port to queue, queue to bus engine
  mem_req_if inst_push_if ();
  mem_req_if inst_pop_if ();
  mem_req_if data_push_if ();
  mem_req_if data_pop_if ();

  logic  inst_rsp_valid;
  logic  inst_rsp_err;
  word_t inst_rsp_data;
  logic  inst_err;
  logic  data_rsp_valid;
  logic  data_rsp_err;
  word_t data_rsp_data;
  logic  data_err;

  // instruction channel, reads only, write side tied off
  core_req_port #(.FIFO_DEPTH(INST_FIFO_DEPTH)) u_inst_port (
    .clk(clk), .reset_i(reset_i),
    .req_i(inst_read_i), .write_i(1'b0), .mask_n_i(NO_WRITE_MASK),
    .addr_i(inst_addr_i), .wdata_i('0),
    .rdata_o(inst_data_o), .stall_o(inst_stall_o),
    .rsp_valid_i(inst_rsp_valid), .rsp_err_i(inst_rsp_err),
    .rsp_data_i(inst_rsp_data), .err_o(inst_err), .req(inst_push_if)
  );

  req_fifo #(.FIFO_DEPTH(INST_FIFO_DEPTH)) u_inst_fifo (
    .clk(clk), .reset_i(reset_i), .in(inst_push_if), .out(inst_pop_if)
  );

  axi_lite_master u_inst_axi (
    .clk(clk), .reset_i(reset_i), .req(inst_pop_if),
    .rsp_valid_o(inst_rsp_valid), .rsp_err_o(inst_rsp_err), .rsp_data_o(inst_rsp_data),
    .awaddr_o(m0_awaddr_o), .awvalid_o(m0_awvalid_o), .awready_i(m0_awready_i),
    .wdata_o(m0_wdata_o), .wstrb_o(m0_wstrb_o), .wvalid_o(m0_wvalid_o),
    .wready_i(m0_wready_i),
    .bresp_i(m0_bresp_i), .bvalid_i(m0_bvalid_i), .bready_o(m0_bready_o),
    .araddr_o(m0_araddr_o), .arvalid_o(m0_arvalid_o), .arready_i(m0_arready_i),
    .rdata_i(m0_rdata_i), .rresp_i(m0_rresp_i), .rvalid_i(m0_rvalid_i),
    .rready_o(m0_rready_o)
  );

  // data channel, one request line for read or write
  core_req_port #(.FIFO_DEPTH(DATA_FIFO_DEPTH)) u_data_port (
    .clk(clk), .reset_i(reset_i),
    .req_i(data_read_i | data_write_i), .write_i(data_write_i),
    .mask_n_i(data_mask_n_i), .addr_i(data_addr_i), .wdata_i(data_wdata_i),
    .rdata_o(data_rdata_o), .stall_o(data_stall_o),
    .rsp_valid_i(data_rsp_valid), .rsp_err_i(data_rsp_err),
    .rsp_data_i(data_rsp_data), .err_o(data_err), .req(data_push_if)
  );

  req_fifo #(.FIFO_DEPTH(DATA_FIFO_DEPTH)) u_data_fifo (
    .clk(clk), .reset_i(reset_i), .in(data_push_if), .out(data_pop_if)
  );

  axi_lite_master u_data_axi (
    .clk(clk), .reset_i(reset_i), .req(data_pop_if),
    .rsp_valid_o(data_rsp_valid), .rsp_err_o(data_rsp_err), .rsp_data_o(data_rsp_data),
    .awaddr_o(m1_awaddr_o), .awvalid_o(m1_awvalid_o), .awready_i(m1_awready_i),
    .wdata_o(m1_wdata_o), .wstrb_o(m1_wstrb_o), .wvalid_o(m1_wvalid_o),
    .wready_i(m1_wready_i),
    .bresp_i(m1_bresp_i), .bvalid_i(m1_bvalid_i), .bready_o(m1_bready_o),
    .araddr_o(m1_araddr_o), .arvalid_o(m1_arvalid_o), .arready_i(m1_arready_i),
    .rdata_i(m1_rdata_i), .rresp_i(m1_rresp_i), .rvalid_i(m1_rvalid_i),
    .rready_o(m1_rready_o)
  );

  // either sticky flag
  assign bus_err_o = inst_err | data_err;

endmodule

// File: testbench/axi_lite_mem_model.sv
`timescale 1ns/1ns

// AXI4-Lite slave memory
// one transaction at a time with ready and response delays of 0 to 3 cycles
module axi_lite_mem_model #(
  parameter logic [31:0] INIT_XOR = 32'h0
) (
  input  logic                    clk,
  input  axi_lite_pkg::axi_addr_t awaddr_i,
  input  logic                    awvalid_i,
  output logic                    awready_o,
  input  axi_lite_pkg::axi_data_t wdata_i,
  input  axi_lite_pkg::axi_strb_t wstrb_i,
  input  logic                    wvalid_i,
  output logic                    wready_o,
  output axi_lite_pkg::axi_resp_e bresp_o,
  output logic                    bvalid_o,
  input  logic                    bready_i,
  input  axi_lite_pkg::axi_addr_t araddr_i,
  input  logic                    arvalid_i,
  output logic                    arready_o,
  output axi_lite_pkg::axi_data_t rdata_o,
  output axi_lite_pkg::axi_resp_e rresp_o,
  output logic                    rvalid_o,
  input  logic                    rready_i,
  // raised when the master holds up a handshake too long
  output logic                    stuck_o
);
  import axi_lite_pkg::*;

  localparam int WAIT_LIMIT = 100;

  // sparse storage by word address where untouched words follow the init rule
  axi_data_t   mem [logic [29:0]];
  logic [31:0] lfsr_q;

  // Galois form with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // two lfsr bits with one step each
  function automatic int unsigned next_delay();
    int unsigned d;
    d = 0;
    for (int i = 0; i < 2; i++) begin
      d = (d << 1) | lfsr_q[0];
      lfsr_q = lfsr_step(lfsr_q);
    end
    return d;
  endfunction

  function automatic axi_data_t word_at(input axi_addr_t addr);
    if (mem.exists(addr[31:2])) begin
      return mem[addr[31:2]];
    end
    return {2'b00, addr[31:2]} ^ INIT_XOR;
  endfunction

  // polls at each edge for rready or bready
  task automatic await_master_ready(input logic is_read);
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < WAIT_LIMIT) begin
      @(posedge clk);
      seen = is_read ? rready_i : bready_i;
      n    = n + 1;
    end
    if (!seen) begin
      stuck_o <= 1'b1;
    end
  endtask

  task automatic serve_read();
    axi_addr_t addr;
    repeat (next_delay()) @(posedge clk);
    arready_o <= 1'b1;
    // handshake lands on this edge
    @(posedge clk);
    addr = araddr_i;
    arready_o <= 1'b0;
    repeat (next_delay()) @(posedge clk);
    rvalid_o <= 1'b1;
    // bit 31 is the error window
    rdata_o  <= addr[31] ? '0 : word_at(addr);
    rresp_o  <= addr[31] ? axi_slverr : axi_okay;
    await_master_ready(1'b1);
    rvalid_o <= 1'b0;
  endtask

  task automatic serve_write();
    axi_addr_t   addr;
    axi_data_t   data;
    axi_strb_t   strb;
    axi_data_t   merged;
    int unsigned aw_wait;
    int unsigned w_wait;
    logic        aw_seen;
    logic        w_seen;
    int          n;
    aw_wait = next_delay();
    w_wait  = next_delay();
    aw_seen = 1'b0;
    w_seen  = 1'b0;
    n       = 0;
    addr    = '0;
    data    = '0;
    strb    = '0;
    // aw and w each wait out their own delay
    while (!(aw_seen && w_seen) && n < WAIT_LIMIT) begin
      awready_o <= !aw_seen && (aw_wait == 0);
      wready_o  <= !w_seen && (w_wait == 0);
      @(posedge clk);
      if (awready_o && awvalid_i) begin
        aw_seen = 1'b1;
        addr    = awaddr_i;
      end
      if (wready_o && wvalid_i) begin
        w_seen = 1'b1;
        data   = wdata_i;
        strb   = wstrb_i;
      end
      if (aw_wait > 0) begin
        aw_wait = aw_wait - 1;
      end
      if (w_wait > 0) begin
        w_wait = w_wait - 1;
      end
      n = n + 1;
    end
    awready_o <= 1'b0;
    wready_o  <= 1'b0;
    if (!(aw_seen && w_seen)) begin
      stuck_o <= 1'b1;
      return;
    end
    merged = word_at(addr);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        merged[8*b +: 8] = data[8*b +: 8];
      end
    end
    // error window leaves memory alone
    if (!addr[31]) begin
      mem[addr[31:2]] = merged;
    end
    repeat (next_delay()) @(posedge clk);
    bvalid_o <= 1'b1;
    bresp_o  <= addr[31] ? axi_slverr : axi_okay;
    await_master_ready(1'b0);
    bvalid_o <= 1'b0;
  endtask

  initial begin
    lfsr_q    = 32'd88275;
    awready_o = 1'b0;
    wready_o  = 1'b0;
    bvalid_o  = 1'b0;
    bresp_o   = axi_okay;
    arready_o = 1'b0;
    rvalid_o  = 1'b0;
    rdata_o   = '0;
    rresp_o   = axi_okay;
    stuck_o   = 1'b0;
    forever begin
      @(posedge clk);
      if (arvalid_i) begin
        serve_read();
      end else if (awvalid_i && wvalid_i) begin
        serve_write();
      end
    end
  end

endmodule

// File: testbench/tb_cpu_wrapper.sv
`timescale 1ns/1ns

// testbench for cpu_wrapper with one memory model per bus
module tb_cpu_wrapper;
  import mem_access_pkg::*;
  import axi_lite_pkg::*;

  localparam logic [31:0] INST_XOR = 32'h5a00_0000;
  localparam logic [31:0] DATA_XOR = 32'h00c3_3c00;
  localparam int WAIT_LIMIT = 400;
  localparam int RAND_OPS = 24;

  logic         clk;
  logic         reset_i;
  logic         inst_read_i;
  addr_t        inst_addr_i;
  word_t        inst_data_o;
  logic         inst_stall_o;
  logic         data_read_i;
  logic         data_write_i;
  byte_mask_n_t data_mask_n_i;
  addr_t        data_addr_i;
  word_t        data_wdata_i;
  word_t        data_rdata_o;
  logic         data_stall_o;
  logic         bus_err_o;

  // bus wires carry the DUT port names
  axi_addr_t m0_awaddr_o, m0_araddr_o, m1_awaddr_o, m1_araddr_o;
  axi_data_t m0_wdata_o, m0_rdata_i, m1_wdata_o, m1_rdata_i;
  axi_strb_t m0_wstrb_o, m1_wstrb_o;
  axi_resp_e m0_bresp_i, m0_rresp_i, m1_bresp_i, m1_rresp_i;
  logic m0_awvalid_o, m0_awready_i, m0_wvalid_o, m0_wready_i, m0_bvalid_i, m0_bready_o;
  logic m0_arvalid_o, m0_arready_i, m0_rvalid_i, m0_rready_o;
  logic m1_awvalid_o, m1_awready_i, m1_wvalid_o, m1_wready_i, m1_bvalid_i, m1_bready_o;
  logic m1_arvalid_o, m1_arready_i, m1_rvalid_i, m1_rready_o;
  logic m0_stuck;
  logic m1_stuck;

  // read in flight per port, its expected word and whether data is checked
  logic  inst_busy, inst_check, data_busy, data_check;
  word_t inst_exp, data_exp;
  int    inst_issued, inst_done, data_issued, data_done;

  logic [31:0]  lfsr_q;
  word_t        data_shadow [logic [29:0]];
  // operations for the concurrent phase drawn before it starts
  addr_t        inst_list [RAND_OPS];
  addr_t        data_list [RAND_OPS];
  word_t        wdat_list [RAND_OPS];
  byte_mask_n_t mask_list [RAND_OPS];
  logic         kind_list [RAND_OPS];

  cpu_wrapper dut0 (.*);

  axi_lite_mem_model #(.INIT_XOR(INST_XOR)) mem0 (
    .clk(clk), .awaddr_i(m0_awaddr_o), .awvalid_i(m0_awvalid_o), .awready_o(m0_awready_i),
    .wdata_i(m0_wdata_o), .wstrb_i(m0_wstrb_o), .wvalid_i(m0_wvalid_o),
    .wready_o(m0_wready_i), .bresp_o(m0_bresp_i), .bvalid_o(m0_bvalid_i),
    .bready_i(m0_bready_o), .araddr_i(m0_araddr_o), .arvalid_i(m0_arvalid_o),
    .arready_o(m0_arready_i), .rdata_o(m0_rdata_i), .rresp_o(m0_rresp_i),
    .rvalid_o(m0_rvalid_i), .rready_i(m0_rready_o), .stuck_o(m0_stuck)
  );

  axi_lite_mem_model #(.INIT_XOR(DATA_XOR)) mem1 (
    .clk(clk), .awaddr_i(m1_awaddr_o), .awvalid_i(m1_awvalid_o), .awready_o(m1_awready_i),
    .wdata_i(m1_wdata_o), .wstrb_i(m1_wstrb_o), .wvalid_i(m1_wvalid_o),
    .wready_o(m1_wready_i), .bresp_o(m1_bresp_i), .bvalid_o(m1_bvalid_i),
    .bready_i(m1_bready_o), .araddr_i(m1_araddr_o), .arvalid_i(m1_arvalid_o),
    .arready_o(m1_arready_i), .rdata_o(m1_rdata_i), .rresp_o(m1_rresp_i),
    .rvalid_o(m1_rvalid_i), .rready_i(m1_rready_o), .stuck_o(m1_stuck)
  );

  // 8 ns period
  always #4 clk = ~clk;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // n fresh bits with one lfsr step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return v;
  endfunction

  // written data words come from the shadow and all others from the init rule
  function automatic word_t expected_read(input logic data_bus, input addr_t addr);
    if (data_bus && data_shadow.exists(addr[31:2])) begin
      return data_shadow[addr[31:2]];
    end
    return {2'b00, addr[31:2]} ^ (data_bus ? DATA_XOR : INST_XOR);
  endfunction

  // zero bits of the active low mask take the new byte
  function automatic void shadow_write(input addr_t addr, input word_t wdata,
                                       input byte_mask_n_t mask_n);
    word_t merged;
    merged = expected_read(1'b1, addr);
    for (int b = 0; b < 4; b++) begin
      if (!mask_n[b]) begin
        merged[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    if (!addr[31]) begin
      data_shadow[addr[31:2]] = merged;
    end
  endfunction

  task automatic abort_run();
    $display("Test failures found");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  // stall is sampled at the falling edge where it is settled
  task automatic wait_inst_free();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n = n + 1;
      if (n > WAIT_LIMIT) begin
        $display("instruction stall did not fall in time");
        abort_run();
      end
    end while (inst_stall_o);
  endtask

  task automatic wait_data_free();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n = n + 1;
      if (n > WAIT_LIMIT) begin
        $display("data stall did not fall in time");
        abort_run();
      end
    end while (data_stall_o);
  endtask

  // called 1 ns after a rising edge and returns 1 ns after a rising edge
  task automatic inst_read(input addr_t addr, input logic check);
    inst_read_i = 1'b1;
    inst_addr_i = addr;
    inst_exp    = expected_read(1'b0, addr);
    inst_check  = check;
    inst_busy   = 1'b1;
    inst_issued = inst_issued + 1;
    wait_inst_free();
    @(posedge clk);
    #1;
    inst_read_i = 1'b0;
    inst_busy   = 1'b0;
  endtask

  task automatic data_read(input addr_t addr, input logic check);
    data_read_i  = 1'b1;
    data_write_i = 1'b0;
    data_addr_i  = addr;
    data_exp     = expected_read(1'b1, addr);
    data_check   = check;
    data_busy    = 1'b1;
    data_issued  = data_issued + 1;
    wait_data_free();
    @(posedge clk);
    #1;
    data_read_i = 1'b0;
    data_busy   = 1'b0;
  endtask

  // posted write returns once the port has taken it
  task automatic data_write(input addr_t addr, input word_t wdata, input byte_mask_n_t mask_n);
    data_write_i  = 1'b1;
    data_read_i   = 1'b0;
    data_addr_i   = addr;
    data_wdata_i  = wdata;
    data_mask_n_i = mask_n;
    shadow_write(addr, wdata, mask_n);
    wait_data_free();
    @(posedge clk);
    #1;
    data_write_i = 1'b0;
  endtask

  // compare each read in the cycle its stall is low
  always @(negedge clk) begin
    if (inst_busy && !inst_stall_o) begin
      if (inst_check) begin
        check_word("instruction port", inst_data_o, inst_exp);
      end
      inst_done = inst_done + 1;
    end
    if (data_busy && !data_stall_o) begin
      if (data_check) begin
        check_word("data port", data_rdata_o, data_exp);
      end
      data_done = data_done + 1;
    end
  end

  // the instruction bus only ever reads
  always @(posedge clk) begin
    if (m0_stuck || m1_stuck) begin
      $display("memory model waited too long on a master handshake");
      abort_run();
    end else if (m0_awvalid_o === 1'b1 || m0_wvalid_o === 1'b1) begin
      $display("instruction bus started a write");
      abort_run();
    end
  end

  initial begin
    addr_t        a;
    word_t        w;
    byte_mask_n_t m;
    clk           = 1'b0;
    reset_i       = 1'b1;
    inst_read_i   = 1'b0;
    inst_addr_i   = '0;
    data_read_i   = 1'b0;
    data_write_i  = 1'b0;
    data_mask_n_i = '1;
    data_addr_i   = '0;
    data_wdata_i  = '0;
    inst_busy     = 1'b0;
    inst_check    = 1'b0;
    data_busy     = 1'b0;
    data_check    = 1'b0;
    inst_exp      = '0;
    data_exp      = '0;
    inst_issued   = 0;
    inst_done     = 0;
    data_issued   = 0;
    data_done     = 0;
    lfsr_q        = 32'd88275;
    for (int i = 0; i < RAND_OPS; i++) begin
      inst_list[i] = rand_bits(10) << 2;
      data_list[i] = rand_bits(4) << 2;
      wdat_list[i] = rand_bits(32);
      mask_list[i] = byte_mask_n_t'(rand_bits(4));
      kind_list[i] = 1'(rand_bits(1));
    end
    repeat (2) @(posedge clk);
    #1;
    reset_i = 1'b0;

    // instruction fetches against the init rule
    for (int i = 0; i < 8; i++) begin
      a = rand_bits(12) << 2;
      inst_read(a, 1'b1);
    end

    // partial masks then read back
    for (int i = 0; i < 8; i++) begin
      a = rand_bits(4) << 2;
      w = rand_bits(32);
      m = byte_mask_n_t'(rand_bits(4));
      data_write(a, w, m);
      data_read(a, 1'b1);
    end
    // all ones mask is a no write
    data_write(32'h0000_0020, 32'hdead_beef, 4'hf);
    data_read(32'h0000_0020, 1'b1);
    // a no write in the error window never reaches the bus
    data_write(32'h8000_0020, 32'hdead_beef, 4'hf);
    data_read(32'h0000_0024, 1'b1);
    check_flag("bus_err_o after a no write", bus_err_o, 1'b0);

    // more writes than queue entries with a read right behind them
    for (int i = 0; i < 6; i++) begin
      data_write(32'h0000_0030, 32'h1111_0000 + i, 4'h0);
    end
    data_write(32'h0000_0030, 32'haabb_ccdd, 4'b1010);
    data_read(32'h0000_0030, 1'b1);

    // both ports at once
    fork
      begin
        for (int i = 0; i < RAND_OPS; i++) begin
          inst_read(inst_list[i], 1'b1);
        end
      end
      begin
        for (int i = 0; i < RAND_OPS; i++) begin
          if (kind_list[i]) begin
            data_write(data_list[i], wdat_list[i], mask_list[i]);
          end else begin
            data_read(data_list[i], 1'b1);
          end
        end
      end
    join

    // error window sets a sticky flag and later accesses still work
    check_flag("bus_err_o before error", bus_err_o, 1'b0);
    data_write(32'h8000_0010, 32'h1234_5678, 4'h0);
    data_read(32'h8000_0010, 1'b0);
    check_flag("bus_err_o after data error", bus_err_o, 1'b1);
    inst_read(32'h8000_0100, 1'b0);
    data_read(32'h0000_0010, 1'b1);
    inst_read(32'h0000_0044, 1'b1);
    check_flag("bus_err_o later", bus_err_o, 1'b1);

    if (inst_done != inst_issued || data_done != data_issued) begin
      $display("some reads finished without being compared");
      abort_run();
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

// File: cpu_wrapper.f
hw/mem_access_pkg.sv
hw/axi_lite_pkg.sv
hw/mem_req_if.sv
hw/core_req_port.sv
hw/req_fifo.sv
hw/axi_lite_master.sv
hw/cpu_wrapper.sv
testbench/axi_lite_mem_model.sv
testbench/tb_cpu_wrapper.sv
